// ==== include/um_defines.svh ====
// CDP user module parameters
// widths, buffer sizing, flow-control thresholds and identity words
`ifndef UM_DEFINES_SVH
`define UM_DEFINES_SVH

`define UM_WORD_W       139     // tag + byte field + port + 128 data bits
`define UM_RULE_W       30
`define UM_LB_W         32
`define UM_FIFO_DEPTH   256
`define UM_USEDW_W      8       // log2 of the buffer depth
`define UM_ADMIT_LIMIT  161     // room for one max-size packet
`define UM_RULE_LIMIT   30      // rule FIFO almost full

`define UM_ID0_RST      32'h0000554D    // ascii "UM"
`define UM_ID1_RST      32'h00000609
`define UM_ID2_RST      32'h00000528
`define UM_ID3_RST      32'h00000526
`define UM_LB_SELECT    4'h1

`endif

// ==== rtl/um_pkg.sv ====
// CDP user module types
// packet word tags, the packet word and local-bus word decodes
`include "um_defines.svh"

package um_pkg;

	typedef enum logic [2:0] {
		TAG_BODY = 3'b100,
		TAG_HEAD = 3'b101,
		TAG_TAIL = 3'b110
	} pkt_tag_e;

	// head word carries the source port, other words are raw payload
	typedef union packed {
		struct packed {
			pkt_tag_e                  tag;
			logic [3:0]                bytes;
			logic [3:0]                in_port;
			logic [`UM_WORD_W-12:0]    data;
		} hdr;
		struct packed {
			pkt_tag_e                  tag;
			logic [`UM_WORD_W-4:0]     raw;
		} body;
	} pkt_word_u;

	typedef enum logic [1:0] {
		LB_REG_ID      = 2'b00,
		LB_REG_SCRATCH = 2'b01
	} lb_region_e;

	// same bus word seen as address phase or as data phase
	typedef union packed {
		struct packed {
			logic [3:0]     sel;
			lb_region_e     region;
			logic [17:0]    rsvd;
			logic [7:0]     index;
		} addr;
		logic [`UM_LB_W-1:0] data;
	} lb_word_u;

endpackage

// ==== rtl/ingress_buffer.sv ====
// ingress buffer
// show-ahead FIFO holding packet words from the input controller,
// and the one-cycle admission strobe that lets the next packet in
`timescale 1ns/1ps
`include "um_defines.svh"

module ingress_buffer
	import um_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        in_valid,
	input  pkt_word_u   in_word,
	input  logic        pop,
	output pkt_word_u   head,
	output logic        empty,
	output logic        admit
);

	localparam logic ADM_IDLE = 1'b0;
	localparam logic ADM_WAIT = 1'b1;   // strobe given, waiting for the packet

	pkt_word_u                  mem [`UM_FIFO_DEPTH];
	logic [`UM_USEDW_W-1:0]     wr_ptr;
	logic [`UM_USEDW_W-1:0]     rd_ptr;
	logic [`UM_USEDW_W:0]       fill;
	logic                       full;
	logic                       do_wr;
	logic                       do_rd;
	logic                       adm_state;

	assign full  = (fill == `UM_FIFO_DEPTH);
	assign empty = (fill == '0);
	assign do_wr = in_valid && !full;  // words into a full buffer are lost
	assign do_rd = pop && !empty;
	assign head  = mem[rd_ptr];        // show-ahead

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= in_word;
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// admit only while the input side is quiet and there is room
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			admit     <= 1'b0;
			adm_state <= ADM_IDLE;
		end
		else
		begin
			case (adm_state)
				ADM_IDLE:
				begin
					admit <= (fill < `UM_ADMIT_LIMIT) && !in_valid;
					if ((fill < `UM_ADMIT_LIMIT) && !in_valid)
						adm_state <= ADM_WAIT;
				end
				default:
				begin
					admit <= 1'b0;  // single-cycle strobe
					if (in_valid)
						adm_state <= ADM_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== rtl/rule_gen.sv ====
// forwarding rule generator
// latches the source port from each head word and, on the tail word,
// writes one rule that floods the packet to every other port
`timescale 1ns/1ps
`include "um_defines.svh"

module rule_gen
	import um_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    in_valid,
	input  pkt_word_u               in_word,
	input  logic [4:0]              rule_usedw,
	output logic [`UM_RULE_W-1:0]   rule,
	output logic                    rule_wrreq
);

	logic [3:0] in_port;    // source port of the packet in flight
	logic       head_seen;
	logic       tail_seen;
	logic       rule_room;
	logic       port_ok;

	assign head_seen = in_valid && (in_word.hdr.tag == TAG_HEAD);
	assign tail_seen = in_valid && (in_word.hdr.tag == TAG_TAIL);
	assign rule_room = (rule_usedw < `UM_RULE_LIMIT);
	assign port_ok   = (in_port[3:2] == 2'b00);  // only ports 0..3 exist

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			in_port    <= 4'd0;
			rule       <= '0;
			rule_wrreq <= 1'b0;
		end
		else
		begin
			rule_wrreq <= 1'b0;
			if (head_seen)
				in_port <= in_word.hdr.in_port;
			else if (tail_seen && rule_room && port_ok)
			begin
				// all four ports except the source, bit 29 stays zero
				rule       <= {{(`UM_RULE_W-4){1'b0}}, ~(4'b0001 << in_port[1:0])};
				rule_wrreq <= 1'b1;
			end
		end
	end

endmodule

// ==== rtl/pass_through.sv ====
// pass-through output FSM
// once the output controller is free, pops one whole packet from the
// ingress buffer and drives it out one word per cycle up to the tail
`timescale 1ns/1ps

module pass_through
	import um_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        out_ready,
	input  pkt_word_u   head,
	input  logic        empty,
	output logic        pop,
	output logic        out_valid,
	output pkt_word_u   out_word
);

	localparam logic ST_IDLE = 1'b0;
	localparam logic ST_FWD  = 1'b1;

	logic state;

	// word on the head is taken on the same edge it is registered out
	assign pop = (state == ST_FWD) && !empty;

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state     <= ST_IDLE;
			out_valid <= 1'b0;
			out_word  <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					out_valid <= 1'b0;
					out_word  <= '0;
					if (out_ready && !empty)   // ready sampled only here
						state <= ST_FWD;
				end
				default:
				begin
					out_valid <= !empty;    // hold off if the packet is still arriving
					if (!empty)
					begin
						out_word <= head;
						if (head.body.tag == TAG_TAIL)
							state <= ST_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// ==== rtl/localbus_regs.sv ====
// local-bus register file
// multiplexed address/data slave with four read-only identity words,
// four writable identity words and eight scratch words
`timescale 1ns/1ps
`include "um_defines.svh"

module localbus_regs
	import um_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    cs_n,
	input  logic                    rd_wr,     // 1 read, 0 write
	input  logic                    ale,
	input  logic [`UM_LB_W-1:0]     bus_in,
	output logic                    ack_n,
	output logic [`UM_LB_W-1:0]     bus_out
);

	localparam logic [2:0] LB_IDLE  = 3'd0;
	localparam logic [2:0] LB_ADDR  = 3'd1;
	localparam logic [2:0] LB_WRITE = 3'd2;
	localparam logic [2:0] LB_READ  = 3'd3;
	localparam logic [2:0] LB_ACK   = 3'd4;

	logic [2:0]             state;
	lb_word_u               bus_word;
	lb_word_u               lb_addr;    // latched in the address phase
	logic [`UM_LB_W-1:0]    wr_data;
	logic [`UM_LB_W-1:0]    id_rw [4];  // identity words 4..7
	logic [`UM_LB_W-1:0]    scratch [8];
	logic [`UM_LB_W-1:0]    rd_data;
	logic                   id_ro_hit;
	logic                   id_rw_hit;
	logic                   scr_hit;

	assign bus_word.data = bus_in;
	assign id_ro_hit = (lb_addr.addr.region == LB_REG_ID) && (lb_addr.addr.index[7:2] == 6'd0);
	assign id_rw_hit = (lb_addr.addr.region == LB_REG_ID) && (lb_addr.addr.index[7:2] == 6'd1);
	assign scr_hit   = (lb_addr.addr.region == LB_REG_SCRATCH) && (lb_addr.addr.index[7:3] == 5'd0);

	always_comb
	begin
		rd_data = '0;   // unmapped space reads as zero
		if (id_ro_hit)
		begin
			case (lb_addr.addr.index[1:0])
				2'd0:    rd_data = `UM_ID0_RST;
				2'd1:    rd_data = `UM_ID1_RST;
				2'd2:    rd_data = `UM_ID2_RST;
				default: rd_data = `UM_ID3_RST;
			endcase
		end
		else if (id_rw_hit)
			rd_data = id_rw[lb_addr.addr.index[1:0]];
		else if (scr_hit)
			rd_data = scratch[lb_addr.addr.index[2:0]];
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state   <= LB_IDLE;
			lb_addr <= '0;
			wr_data <= '0;
			ack_n   <= 1'b1;
			bus_out <= '0;
			for (int i = 0; i < 4; i++)
				id_rw[i] <= '0;
			for (int i = 0; i < 8; i++)
				scratch[i] <= '0;
		end
		else
		begin
			case (state)
				LB_IDLE:
				begin
					if (ale && (bus_word.addr.sel == `UM_LB_SELECT))
					begin
						lb_addr <= bus_word;
						state   <= LB_ADDR;
					end
				end
				LB_ADDR:
				begin
					if (!cs_n)
					begin
						wr_data <= bus_in;
						state   <= rd_wr ? LB_READ : LB_WRITE;
					end
				end
				LB_WRITE:
				begin
					if (id_rw_hit)
						id_rw[lb_addr.addr.index[1:0]] <= wr_data;
					else if (scr_hit)
						scratch[lb_addr.addr.index[2:0]] <= wr_data;
					ack_n <= 1'b0;  // read-only and unmapped writes still ack
					state <= LB_ACK;
				end
				LB_READ:
				begin
					bus_out <= rd_data;
					ack_n   <= 1'b0;
					state   <= LB_ACK;
				end
				default:
				begin
					if (cs_n)   // host has released the cycle
					begin
						ack_n <= 1'b1;
						state <= LB_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// ==== rtl/um_top.sv ====
// CDP user module top level
// ingress buffer, pass-through, rule generation and local-bus registers
// beside the switch's input and output controllers
`timescale 1ns/1ps
`include "um_defines.svh"

module um_top
	import um_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    localbus_cs_n,
	input  logic                    localbus_rd_wr,
	input  logic [`UM_LB_W-1:0]     localbus_data,
	input  logic                    localbus_ale,
	output logic                    localbus_ack_n,
	output logic [`UM_LB_W-1:0]     localbus_data_out,
	input  logic                    cdp2um_data_valid,
	input  logic [`UM_WORD_W-1:0]   cdp2um_data,
	output logic                    um2cdp_tx_enable,
	output logic                    um2cdp_data_valid,
	output logic [`UM_WORD_W-1:0]   um2cdp_data,
	input  logic                    cdp2um_tx_enable,
	output logic [`UM_RULE_W-1:0]   um2cdp_rule,
	output logic                    um2cdp_rule_wrreq,
	input  logic [4:0]              cdp2um_rule_usedw
);

	pkt_word_u  buf_word;   // show-ahead head of the buffer
	logic       buf_empty;
	logic       buf_pop;

	ingress_buffer u_buf (
		.clk      (clk),
		.reset    (reset),
		.in_valid (cdp2um_data_valid),
		.in_word  (cdp2um_data),
		.pop      (buf_pop),
		.head     (buf_word),
		.empty    (buf_empty),
		.admit    (um2cdp_tx_enable)
	);

	// snoops the same input stream as the buffer
	rule_gen u_rule (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (cdp2um_data_valid),
		.in_word    (cdp2um_data),
		.rule_usedw (cdp2um_rule_usedw),
		.rule       (um2cdp_rule),
		.rule_wrreq (um2cdp_rule_wrreq)
	);

	pass_through u_pass (
		.clk       (clk),
		.reset     (reset),
		.out_ready (cdp2um_tx_enable),
		.head      (buf_word),
		.empty     (buf_empty),
		.pop       (buf_pop),
		.out_valid (um2cdp_data_valid),
		.out_word  (um2cdp_data)
	);

	localbus_regs u_lb (
		.clk     (clk),
		.reset   (reset),
		.cs_n    (localbus_cs_n),
		.rd_wr   (localbus_rd_wr),
		.ale     (localbus_ale),
		.bus_in  (localbus_data),
		.ack_n   (localbus_ack_n),
		.bus_out (localbus_data_out)
	);

endmodule

// ==== sim/tb_clkgen.sv ====
// testbench clock and reset
// free-running clock, active-low reset held for the first two cycles
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD = 40
) (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk   = 1'b0;
		reset = 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b1;
	end

	always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== sim/um_props.sv ====
// CDP user module protocol properties
// strobes stay single-cycle, output packets open with a head word,
// and the local-bus acknowledge follows chip select
`timescale 1ns/1ps
`include "um_defines.svh"

module um_props
	import um_pkg::*;
(
	input logic                     clk,
	input logic                     reset,
	input logic                     um2cdp_rule_wrreq,
	input logic                     um2cdp_tx_enable,
	input logic                     um2cdp_data_valid,
	input logic [`UM_WORD_W-1:0]    um2cdp_data,
	input logic                     localbus_cs_n,
	input logic                     localbus_ack_n
);

	int assert_fails = 0;   // number of failed assertions so far

	rule_wrreq_single: assert property (@(posedge clk) disable iff (!reset)
		um2cdp_rule_wrreq |=> !um2cdp_rule_wrreq)
	else
	begin
		assert_fails++;
		$error("rule_wrreq held high for two cycles");
	end

	// first valid word after a gap opens a packet
	out_starts_with_head: assert property (@(posedge clk) disable iff (!reset)
		$rose(um2cdp_data_valid) |-> (um2cdp_data[`UM_WORD_W-1 -: 3] == TAG_HEAD))
	else
	begin
		assert_fails++;
		$error("output packet does not start with a head word");
	end

	tx_enable_single: assert property (@(posedge clk) disable iff (!reset)
		um2cdp_tx_enable |=> !um2cdp_tx_enable)
	else
	begin
		assert_fails++;
		$error("tx_enable held high for two cycles");
	end

	ack_follows_cs: assert property (@(posedge clk) disable iff (!reset)
		localbus_cs_n |=> localbus_ack_n)
	else
	begin
		assert_fails++;
		$error("ack_n low although cs_n was high");
	end

endmodule

bind um_top um_props u_props (.*);

// ==== sim/um_tb.sv ====
// CDP user module testbench
// runs register and packet commands from a trace file, checks the
// output stream and the rule writes, and prints a summary
`timescale 1ns/1ps
`include "um_defines.svh"

module um_tb
	import um_pkg::*;
();

	logic                   clk;
	logic                   reset;
	logic                   localbus_cs_n;
	logic                   localbus_rd_wr;
	logic [`UM_LB_W-1:0]    localbus_data;
	logic                   localbus_ale;
	logic                   localbus_ack_n;
	logic [`UM_LB_W-1:0]    localbus_data_out;
	logic                   cdp2um_data_valid;
	logic [`UM_WORD_W-1:0]  cdp2um_data;
	logic                   um2cdp_tx_enable;
	logic                   um2cdp_data_valid;
	logic [`UM_WORD_W-1:0]  um2cdp_data;
	logic                   cdp2um_tx_enable;
	logic [`UM_RULE_W-1:0]  um2cdp_rule;
	logic                   um2cdp_rule_wrreq;
	logic [4:0]             cdp2um_rule_usedw;

	int                     checks = 0;
	int                     errors = 0;
	int                     n_lines = 0;
	logic                   trace_ready = 1'b0;
	logic                   admitted = 1'b0;   // admission strobe seen, not yet used
	logic                   in_out_pkt = 1'b0;
	logic [31:0]            lfsr_state = 32'h345a9d9d;
	logic [`UM_WORD_W-1:0]  word_q [$];        // words sent, not yet seen on the output
	logic [`UM_RULE_W-1:0]  rule_q [$];
	logic [`UM_WORD_W-1:0]  exp_word;
	logic [`UM_RULE_W-1:0]  exp_rule;

	tb_clkgen #(.PERIOD(40)) u_clkgen (
		.clk   (clk),
		.reset (reset)
	);

	um_top u_dut (
		.clk               (clk),
		.reset             (reset),
		.localbus_cs_n     (localbus_cs_n),
		.localbus_rd_wr    (localbus_rd_wr),
		.localbus_data     (localbus_data),
		.localbus_ale      (localbus_ale),
		.localbus_ack_n    (localbus_ack_n),
		.localbus_data_out (localbus_data_out),
		.cdp2um_data_valid (cdp2um_data_valid),
		.cdp2um_data       (cdp2um_data),
		.um2cdp_tx_enable  (um2cdp_tx_enable),
		.um2cdp_data_valid (um2cdp_data_valid),
		.um2cdp_data       (um2cdp_data),
		.cdp2um_tx_enable  (cdp2um_tx_enable),
		.um2cdp_rule       (um2cdp_rule),
		.um2cdp_rule_wrreq (um2cdp_rule_wrreq),
		.cdp2um_rule_usedw (cdp2um_rule_usedw)
	);

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [135:0] rand_bits(input int nbits);
		logic [135:0] v;
		v = '0;
		for (int i = 0; i < nbits; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v[i] = lfsr_state[0];
		end
		return v;
	endfunction

	// address phase, then data phase held until the acknowledge
	task automatic bus_access(input logic is_read, input logic [31:0] addr,
		input logic [31:0] value);
		lb_word_u   a;
		int         wait_cnt;
		logic       acked;
		a.data = addr;
		@(posedge clk);
		localbus_ale  <= 1'b1;
		localbus_data <= a.data;
		@(posedge clk);
		localbus_ale   <= 1'b0;
		localbus_cs_n  <= 1'b0;
		localbus_rd_wr <= is_read;
		localbus_data  <= is_read ? 32'h0 : value;
		acked    = 1'b0;
		wait_cnt = 0;
		while (!acked && wait_cnt < 16)
		begin
			@(negedge clk);
			acked = !localbus_ack_n;
			wait_cnt++;
		end
		checks++;
		if (!acked)
		begin
			errors++;
			$display("no acknowledge for access to address %h", a.data);
		end
		else if (is_read && localbus_data_out !== value)
		begin
			errors++;
			$display("Mismatch localbus_data_out at %h: expected %h, got %h",
				a.data, value, localbus_data_out);
		end
		@(posedge clk);
		localbus_cs_n <= 1'b1;
		wait_cnt = 0;
		while (!localbus_ack_n && wait_cnt < 16)
		begin
			@(negedge clk);
			wait_cnt++;
		end
		if (!localbus_ack_n)
		begin
			errors++;
			$display("acknowledge stuck low after access to %h", a.data);
		end
	endtask

	task automatic send_packet(input int port, input int len, input logic has_rule,
		input logic [`UM_RULE_W-1:0] rule);
		pkt_word_u      w;
		logic [135:0]   bits;
		int             wait_cnt;
		wait_cnt = 0;
		while (!admitted && wait_cnt < 200)
		begin
			@(negedge clk);
			wait_cnt++;
		end
		if (!admitted)
		begin
			errors++;
			$display("no admission strobe before packet from port %0d", port);
		end
		admitted = 1'b0;
		if (has_rule)
			rule_q.push_back(rule);
		for (int i = 0; i < len; i++)
		begin
			bits = rand_bits(i == 0 ? 132 : 136);
			if (i == 0)
			begin
				w.hdr.tag     = TAG_HEAD;
				w.hdr.bytes   = bits[131:128];
				w.hdr.in_port = port[3:0];
				w.hdr.data    = bits[127:0];
			end
			else
			begin
				w.body.tag = (i == len - 1) ? TAG_TAIL : TAG_BODY;
				w.body.raw = bits;
			end
			word_q.push_back(w);
			@(posedge clk);
			cdp2um_data_valid <= 1'b1;
			cdp2um_data       <= w;
		end
		@(posedge clk);
		cdp2um_data_valid <= 1'b0;
		// rule pulse is due one cycle after the tail
		@(posedge clk);
		checks++;
		if (rule_q.size() != 0)
		begin
			errors++;
			$display("rule write missing for packet from port %0d", port);
			rule_q.delete();
		end
	endtask

	task automatic drain_output();
		int wait_cnt;
		wait_cnt = 0;
		while (word_q.size() != 0 && wait_cnt < 1000)
		begin
			@(negedge clk);
			wait_cnt++;
		end
		checks++;
		if (word_q.size() != 0)
		begin
			errors++;
			$display("%0d packet words never reached the output", word_q.size());
			word_q.delete();
		end
	endtask

	always @(negedge clk)
	begin
		if (reset && um2cdp_tx_enable)
			admitted = 1'b1;
	end

	// output stream against the sent words
	always @(negedge clk)
	begin
		if (reset && um2cdp_data_valid)
		begin
			checks++;
			if (!cdp2um_tx_enable)
			begin
				errors++;
				$display("output word while cdp2um_tx_enable was low");
			end
			if (word_q.size() == 0)
			begin
				errors++;
				$display("output word %h with no packet sent", um2cdp_data);
			end
			else
			begin
				exp_word = word_q.pop_front();
				if (um2cdp_data !== exp_word)
				begin
					errors++;
					$display("Mismatch um2cdp_data: expected %h, got %h", exp_word, um2cdp_data);
				end
			end
			in_out_pkt = (um2cdp_data[`UM_WORD_W-1 -: 3] != TAG_TAIL);
		end
		else if (reset && in_out_pkt)
		begin
			errors++;
			$display("output packet interrupted before its tail word");
			in_out_pkt = 1'b0;
		end
	end

	always @(negedge clk)
	begin
		if (reset && um2cdp_rule_wrreq)
		begin
			checks++;
			if (rule_q.size() == 0)
			begin
				errors++;
				$display("unexpected rule write %h", um2cdp_rule);
			end
			else
			begin
				exp_rule = rule_q.pop_front();
				if (um2cdp_rule !== exp_rule)
				begin
					errors++;
					$display("Mismatch um2cdp_rule: expected %h, got %h", exp_rule, um2cdp_rule);
				end
			end
		end
	end

	initial
	begin
		wait (trace_ready);
		repeat (n_lines * 400) @(posedge clk);
		$display("timeout: trace not finished after %0d cycles", n_lines * 400);
		$display("checks %0d, errors %0d", checks, errors + 1);
		$display("Some tests failed");
		$finish;
	end

	initial
	begin
		int                     fd;
		int                     n;
		string                  line;
		string                  cmd;
		string                  rule_s;
		logic [31:0]            addr;
		logic [31:0]            value;
		int                     port;
		int                     len;
		int                     level;
		logic [`UM_RULE_W-1:0]  rule;
		localbus_cs_n     = 1'b1;
		localbus_rd_wr    = 1'b1;
		localbus_data     = '0;
		localbus_ale      = 1'b0;
		cdp2um_data_valid = 1'b0;
		cdp2um_data       = '0;
		cdp2um_tx_enable  = 1'b1;
		cdp2um_rule_usedw = 5'd0;
		fd = $fopen("sim/um_trace.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("cannot open the trace file sim/um_trace.txt");
		end
		else
		begin
			while ($fgets(line, fd) != 0)
				n_lines++;
			$fclose(fd);
			trace_ready = 1'b1;
			fd = $fopen("sim/um_trace.txt", "r");
			wait (reset === 1'b1);
			@(posedge clk);
			while ($fgets(line, fd) != 0)
			begin
				n = $sscanf(line, "%s", cmd);
				if (n != 1 || cmd.getc(0) == "#")
					continue;   // blank or comment
				if (cmd == "W" || cmd == "R")
				begin
					n = $sscanf(line, "%s %h %h", cmd, addr, value);
					bus_access(cmd == "R", addr, value);
				end
				else if (cmd == "P")
				begin
					n = $sscanf(line, "%s %d %d %s", cmd, port, len, rule_s);
					if (rule_s == "none")
						send_packet(port, len, 1'b0, '0);
					else
					begin
						n = $sscanf(rule_s, "%h", rule);
						send_packet(port, len, 1'b1, rule);
					end
				end
				else if (cmd == "U")
				begin
					n = $sscanf(line, "%s %d", cmd, level);
					@(posedge clk);
					cdp2um_rule_usedw <= level[4:0];
				end
				else if (cmd == "E")
				begin
					n = $sscanf(line, "%s %d", cmd, level);
					if (level == 0)
						drain_output();  // nothing may be in flight when it drops
					@(posedge clk);
					cdp2um_tx_enable <= (level != 0);
					if (level != 0)
						drain_output();
				end
				else
				begin
					errors++;
					$display("unknown trace command %s", cmd);
				end
			end
			$fclose(fd);
			drain_output();
			repeat (4) @(negedge clk);
		end
		errors = errors + u_dut.u_props.assert_fails;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== sim/um_trace.txt ====
# W addr data | R addr expected | P port words rule (none: no rule expected)
# U rule_usedw level | E cdp2um_tx_enable level (addr, data, rule in hex)
R 10000000 0000554d
R 10000001 00000609
R 10000002 00000528
R 10000003 00000526
W 10000000 ffffffff
W 10000003 12345678
R 10000000 0000554d
R 10000003 00000526
W 10000004 a5a5a5a5
W 10000007 5a5a0001
W 14000000 deadbeef
W 14000007 00c0ffee
R 10000004 a5a5a5a5
R 10000007 5a5a0001
R 14000000 deadbeef
R 14000007 00c0ffee
W 18000000 11111111
R 18000000 00000000
R 1c000005 00000000
R 10000010 00000000
R 14000008 00000000
P 0 2 0000000e
P 1 5 0000000d
P 2 3 0000000b
P 3 9 00000007
P 5 4 none
U 30
P 2 6 none
U 0
E 0
P 0 3 0000000e
P 3 2 00000007
E 1

// ==== tb.f ====
+incdir+include
rtl/um_pkg.sv
rtl/ingress_buffer.sv
rtl/rule_gen.sv
rtl/pass_through.sv
rtl/localbus_regs.sv
rtl/um_top.sv
sim/tb_clkgen.sv
sim/um_props.sv
sim/um_tb.sv

// ==== Bender.yml ====
package:
  name: cdp_user_module

export_include_dirs:
  - include

sources:
  - files:
      - rtl/um_pkg.sv
      - rtl/ingress_buffer.sv
      - rtl/rule_gen.sv
      - rtl/pass_through.sv
      - rtl/localbus_regs.sv
      - rtl/um_top.sv
  - target: simulation
    files:
      - sim/tb_clkgen.sv
      - sim/um_props.sv
      - sim/um_tb.sv
